//--- Makefile
# Verilator flow for the host-channel shim

TOP = mpf_shim_tb
RTL = hw/mpf_shim_pkg.sv hw/mpf_req_map.sv hw/mpf_tx_fifo.sv hw/mpf_rsp_map.sv hw/mpf_shim_top.sv

.PHONY: lint sim clean

lint:
	verilator --lint-only --assert $(RTL) --top-module mpf_shim_top
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

//--- bench/mpf_shim_tb.sv
// Testbench for the host-channel shim, acting as both the AFU and the FIU.
// Stimulus comes from a 16-bit Fibonacci LFSR, so every run is identical.
// A per-cycle model of FIFO fill and credit use predicts both AFU almost-full outputs.
// Inputs change 1 ns after the rising edge and every check runs on the falling edge.
// The first failing check ends the run.

`timescale 1ns/1ps

module mpf_shim_tb;
    import mpf_shim_pkg::*;

    localparam int clk_half   = 2;
    localparam int wait_limit = 2000;

    logic                clk;
    logic                arst_n;
    logic                afu_c0_valid;
    logic [addr_w-1:0]   afu_c0_addr;
    logic [mdata_w-1:0]  afu_c0_mdata;
    logic                afu_c1_valid;
    t_req_op             afu_c1_op;
    logic [addr_w-1:0]   afu_c1_addr;
    logic [data_w-1:0]   afu_c1_data;
    logic [mdata_w-1:0]  afu_c1_mdata;
    logic                c0_ext_vaddr;
    logic                c0_ext_order;
    logic                c1_ext_vaddr;
    logic                c1_ext_order;
    logic                c1_pwrite_en;
    logic [mask_w-1:0]   c1_pwrite_mask;
    logic                afu_c0_alm_full;
    logic                afu_c1_alm_full;
    logic                afu_rx0_valid;
    logic [data_w-1:0]   afu_rx0_data;
    logic [mdata_w-1:0]  afu_rx0_mdata;
    logic                afu_rx1_valid;
    t_rsp_op             afu_rx1_op;
    logic [mdata_w-1:0]  afu_rx1_mdata;
    logic                fiu_c0_valid;
    logic [addr_w-1:0]   fiu_c0_addr;
    logic [mdata_w-1:0]  fiu_c0_mdata;
    logic                fiu_c0_vaddr;
    logic                fiu_c0_order;
    logic                fiu_c1_valid;
    t_req_op             fiu_c1_op;
    logic [addr_w-1:0]   fiu_c1_addr;
    logic [data_w-1:0]   fiu_c1_data;
    logic [mask_w-1:0]   fiu_c1_mask;
    logic [mdata_w-1:0]  fiu_c1_mdata;
    logic                fiu_c1_vaddr;
    logic                fiu_c1_order;
    logic                fiu_c0_alm_full;
    logic                fiu_c1_alm_full;
    logic                fiu_rx0_valid;
    logic [data_w-1:0]   fiu_rx0_data;
    logic [mdata_w-1:0]  fiu_rx0_mdata;
    logic                fiu_rx1_valid;
    t_rsp_op             fiu_rx1_op;
    logic [mdata_w-1:0]  fiu_rx1_mdata;

    // Stimulus state and test phase controls
    logic [15:0]         lfsr;
    logic [mdata_w-1:0]  next_tag;
    int                  req_left0;
    int                  req_left1;
    int                  burst_left;
    bit                  stall_fiu;
    bit                  burst_fiu;
    bit                  hold_rsp;

    // Requests the FIU should see next, one queue per field
    logic [addr_w-1:0]   exp0_addr_q[$];
    logic [mdata_w-1:0]  exp0_mdata_q[$];
    logic [1:0]          exp0_ext_q[$];
    t_req_op             exp1_op_q[$];
    logic [addr_w-1:0]   exp1_addr_q[$];
    logic [data_w-1:0]   exp1_data_q[$];
    logic [mask_w-1:0]   exp1_mask_q[$];
    logic [mdata_w-1:0]  exp1_mdata_q[$];
    logic [1:0]          exp1_ext_q[$];

    // Responses the FIU model still owes
    logic [mdata_w-1:0]  rsp0_mdata_q[$];
    logic [mdata_w-1:0]  rsp1_mdata_q[$];
    t_rsp_op             rsp1_op_q[$];

    // Flow model, valid at the falling edge for the state after the last rising edge
    int                  fifo0_cnt;
    int                  fifo1_cnt;
    int                  credits_used;
    bit                  c0_mapped;
    bit                  c1_mapped;

    // FIU responses of the previous cycle, due on the AFU side now
    bit                  prev_rx0_valid;
    logic [data_w-1:0]   prev_rx0_data;
    logic [mdata_w-1:0]  prev_rx0_mdata;
    bit                  prev_rx1_valid;
    t_rsp_op             prev_rx1_op;
    logic [mdata_w-1:0]  prev_rx1_mdata;

    mpf_shim_top mpf_shim_top_i (.*);

    always #clk_half clk = ~clk;

    // Taps 16, 14, 13 and 11, shifted toward the MSB
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit taken
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic bit coin();
        return take_bits(1) == 64'd1;
    endfunction

    task automatic value_error(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        $display("error at time %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic rule_error(input string what);
        $display("error at time %0t: %s", $time, what);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_field(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got == exp) else value_error(name, got, exp);
    endtask

    // FIU almost-full is either forced high, held low or toggled in random bursts
    task automatic drive_fiu_flow();
        if (stall_fiu)
        begin
            fiu_c0_alm_full = 1'b1;
            fiu_c1_alm_full = 1'b1;
        end
        else if (!burst_fiu)
        begin
            fiu_c0_alm_full = 1'b0;
            fiu_c1_alm_full = 1'b0;
        end
        else
        begin
            if (burst_left == 0)
            begin
                fiu_c0_alm_full = coin();
                fiu_c1_alm_full = coin();
                burst_left = int'(take_bits(3)) + 1;
            end
            burst_left--;
        end
    endtask

    // Each owed response goes out after a random number of idle cycles
    task automatic drive_responses();
        fiu_rx0_valid = 1'b0;
        fiu_rx1_valid = 1'b0;
        if (!hold_rsp && rsp0_mdata_q.size() > 0 && coin())
        begin
            fiu_rx0_valid = 1'b1;
            fiu_rx0_data  = data_w'(take_bits(data_w));
            fiu_rx0_mdata = rsp0_mdata_q.pop_front();
        end
        if (!hold_rsp && rsp1_mdata_q.size() > 0 && coin())
        begin
            fiu_rx1_valid = 1'b1;
            fiu_rx1_op    = rsp1_op_q.pop_front();
            fiu_rx1_mdata = rsp1_mdata_q.pop_front();
        end
    endtask

    // AFU side, which never issues while its almost-full is high
    task automatic drive_requests();
        logic [data_w-1:0] exp_data;
        logic [mask_w-1:0] exp_mask;
        afu_c0_valid = 1'b0;
        afu_c1_valid = 1'b0;
        if (req_left0 > 0 && !afu_c0_alm_full && coin())
        begin
            afu_c0_valid = 1'b1;
            afu_c0_addr  = addr_w'(take_bits(addr_w));
            afu_c0_mdata = next_tag;
            c0_ext_vaddr = coin();
            c0_ext_order = coin();
            next_tag     = next_tag + 1'b1;
            req_left0--;
            exp0_addr_q.push_back(afu_c0_addr);
            exp0_mdata_q.push_back(afu_c0_mdata);
            exp0_ext_q.push_back({c0_ext_vaddr, c0_ext_order});
        end
        if (req_left1 > 0 && !afu_c1_alm_full && coin())
        begin
            afu_c1_valid   = 1'b1;
            afu_c1_op      = (take_bits(2) == 64'd0) ? req_wrfence : req_wrline;
            afu_c1_addr    = addr_w'(take_bits(addr_w));
            afu_c1_data    = data_w'(take_bits(data_w));
            afu_c1_mdata   = next_tag;
            c1_ext_vaddr   = coin();
            c1_ext_order   = coin();
            c1_pwrite_en   = coin();
            c1_pwrite_mask = mask_w'(take_bits(mask_w));
            next_tag       = next_tag + 1'b1;
            req_left1--;
            // A fence drops data and mask, a write keeps every byte unless pwrite applies
            exp_data = afu_c1_data;
            exp_mask = '1;
            if (afu_c1_op == req_wrfence)
            begin
                exp_data = '0;
                exp_mask = '0;
            end
            else if (c1_pwrite_en)
                exp_mask = c1_pwrite_mask;
            exp1_op_q.push_back(afu_c1_op);
            exp1_addr_q.push_back(afu_c1_addr);
            exp1_data_q.push_back(exp_data);
            exp1_mask_q.push_back(exp_mask);
            exp1_mdata_q.push_back(afu_c1_mdata);
            exp1_ext_q.push_back({c1_ext_vaddr, c1_ext_order});
        end
    endtask

    // FIU requests must match the oldest pending AFU request of their channel
    task automatic check_requests();
        if (fiu_c0_valid)
        begin
            assert (!fiu_c0_alm_full) else rule_error("FIU c0 request while FIU almost full");
            assert (exp0_addr_q.size() > 0) else rule_error("FIU c0 request nobody issued");
            check_field("fiu_c0_addr", 64'(fiu_c0_addr), 64'(exp0_addr_q[0]));
            check_field("fiu_c0_mdata", 64'(fiu_c0_mdata), 64'(exp0_mdata_q[0]));
            check_field("fiu_c0_vaddr", 64'(fiu_c0_vaddr), 64'(exp0_ext_q[0][1]));
            check_field("fiu_c0_order", 64'(fiu_c0_order), 64'(exp0_ext_q[0][0]));
            rsp0_mdata_q.push_back(fiu_c0_mdata);
            void'(exp0_addr_q.pop_front());
            void'(exp0_mdata_q.pop_front());
            void'(exp0_ext_q.pop_front());
        end
        if (fiu_c1_valid)
        begin
            assert (!fiu_c1_alm_full) else rule_error("FIU c1 request while FIU almost full");
            assert (exp1_op_q.size() > 0) else rule_error("FIU c1 request nobody issued");
            check_field("fiu_c1_op", 64'(fiu_c1_op), 64'(exp1_op_q[0]));
            check_field("fiu_c1_addr", 64'(fiu_c1_addr), 64'(exp1_addr_q[0]));
            check_field("fiu_c1_data", 64'(fiu_c1_data), 64'(exp1_data_q[0]));
            check_field("fiu_c1_mask", 64'(fiu_c1_mask), 64'(exp1_mask_q[0]));
            check_field("fiu_c1_mdata", 64'(fiu_c1_mdata), 64'(exp1_mdata_q[0]));
            check_field("fiu_c1_vaddr", 64'(fiu_c1_vaddr), 64'(exp1_ext_q[0][1]));
            check_field("fiu_c1_order", 64'(fiu_c1_order), 64'(exp1_ext_q[0][0]));
            rsp1_mdata_q.push_back(fiu_c1_mdata);
            rsp1_op_q.push_back((exp1_op_q[0] == req_wrfence) ? rsp_wrfence : rsp_wrline);
            void'(exp1_op_q.pop_front());
            void'(exp1_addr_q.pop_front());
            void'(exp1_data_q.pop_front());
            void'(exp1_mask_q.pop_front());
            void'(exp1_mdata_q.pop_front());
            void'(exp1_ext_q.pop_front());
        end
    endtask

    // AFU responses repeat the FIU responses of exactly one cycle before
    task automatic check_responses();
        check_field("afu_rx0_valid", 64'(afu_rx0_valid), 64'(prev_rx0_valid));
        check_field("afu_rx1_valid", 64'(afu_rx1_valid), 64'(prev_rx1_valid));
        if (prev_rx0_valid)
        begin
            check_field("afu_rx0_data", 64'(afu_rx0_data), 64'(prev_rx0_data));
            check_field("afu_rx0_mdata", 64'(afu_rx0_mdata), 64'(prev_rx0_mdata));
        end
        if (prev_rx1_valid)
        begin
            check_field("afu_rx1_op", 64'(afu_rx1_op), 64'(prev_rx1_op));
            check_field("afu_rx1_mdata", 64'(afu_rx1_mdata), 64'(prev_rx1_mdata));
        end
        prev_rx0_valid = fiu_rx0_valid;
        prev_rx0_data  = fiu_rx0_data;
        prev_rx0_mdata = fiu_rx0_mdata;
        prev_rx1_valid = fiu_rx1_valid;
        prev_rx1_op    = fiu_rx1_op;
        prev_rx1_mdata = fiu_rx1_mdata;
    endtask

    // A request enters its FIFO two edges after the AFU valid and takes a credit there
    task automatic check_flow_control();
        bit credit_low;
        credit_low = credits_used >= max_outstanding - alm_full_slack;
        check_field("afu_c0_alm_full", 64'(afu_c0_alm_full),
                    64'(fifo0_cnt >= tx_depth - alm_full_slack || credit_low));
        check_field("afu_c1_alm_full", 64'(afu_c1_alm_full),
                    64'(fifo1_cnt >= tx_depth - alm_full_slack || credit_low));
        if (c0_mapped)
        begin
            fifo0_cnt++;
            credits_used++;
        end
        if (c1_mapped)
        begin
            fifo1_cnt++;
            credits_used++;
        end
        if (fiu_c0_valid)
            fifo0_cnt--;
        if (fiu_c1_valid)
            fifo1_cnt--;
        if (fiu_rx0_valid)
            credits_used--;
        if (fiu_rx1_valid)
            credits_used--;
        c0_mapped = afu_c0_valid;
        c1_mapped = afu_c1_valid;
    endtask

    // One clock cycle: drive after the rising edge, check at the falling edge
    task automatic step();
        @(posedge clk);
        #1;
        drive_fiu_flow();
        drive_responses();
        drive_requests();
        @(negedge clk);
        check_requests();
        check_responses();
        check_flow_control();
    endtask

    task automatic wait_drained(input string what);
        int n;
        n = 0;
        while (req_left0 != 0 || req_left1 != 0 || exp0_addr_q.size() != 0 ||
               exp1_op_q.size() != 0 || rsp0_mdata_q.size() != 0 ||
               rsp1_mdata_q.size() != 0 || credits_used != 0 || c0_mapped || c1_mapped)
        begin
            step();
            n++;
            if (n > wait_limit)
                rule_error({"timed out waiting for ", what});
        end
    endtask

    initial
    begin
        int n;
        clk            = 1'b0;
        arst_n         = 1'b0;
        lfsr           = 16'd37488;
        next_tag       = '0;
        afu_c0_valid   = 1'b0;
        afu_c0_addr    = '0;
        afu_c0_mdata   = '0;
        afu_c1_valid   = 1'b0;
        afu_c1_op      = req_wrline;
        afu_c1_addr    = '0;
        afu_c1_data    = '0;
        afu_c1_mdata   = '0;
        c0_ext_vaddr   = 1'b0;
        c0_ext_order   = 1'b0;
        c1_ext_vaddr   = 1'b0;
        c1_ext_order   = 1'b0;
        c1_pwrite_en   = 1'b0;
        c1_pwrite_mask = '0;
        fiu_c0_alm_full = 1'b0;
        fiu_c1_alm_full = 1'b0;
        fiu_rx0_valid  = 1'b0;
        fiu_rx0_data   = '0;
        fiu_rx0_mdata  = '0;
        fiu_rx1_valid  = 1'b0;
        fiu_rx1_op     = rsp_wrline;
        fiu_rx1_mdata  = '0;
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // Nothing may leave the shim straight after reset
        @(negedge clk);
        check_field("fiu_c0_valid", 64'(fiu_c0_valid), 64'd0);
        check_field("fiu_c1_valid", 64'(fiu_c1_valid), 64'd0);
        check_field("afu_rx0_valid", 64'(afu_rx0_valid), 64'd0);
        check_field("afu_rx1_valid", 64'(afu_rx1_valid), 64'd0);
        check_field("afu_c0_alm_full", 64'(afu_c0_alm_full), 64'd0);
        check_field("afu_c1_alm_full", 64'(afu_c1_alm_full), 64'd0);

        // Reads, writes and fences with a free-running FIU
        req_left0 = 24;
        req_left1 = 24;
        wait_drained("basic traffic to drain");

        // FIU back-pressure fills the c1 FIFO until the AFU is told to stop
        stall_fiu = 1'b1;
        req_left1 = 20;
        n = 0;
        while (!afu_c1_alm_full)
        begin
            step();
            n++;
            if (n > wait_limit)
                rule_error("timed out waiting for afu_c1_alm_full under FIU stall");
        end
        req_left1 = 0;
        repeat (4) step();
        stall_fiu = 1'b0;
        wait_drained("stalled c1 requests to drain");

        // Withheld responses use up the shared credits on both channels
        hold_rsp  = 1'b1;
        req_left0 = 100;
        req_left1 = 100;
        n = 0;
        while (!(afu_c0_alm_full && afu_c1_alm_full))
        begin
            step();
            n++;
            if (n > wait_limit)
                rule_error("timed out waiting for credit almost-full");
        end
        req_left0 = 0;
        req_left1 = 0;
        repeat (3) step();
        hold_rsp = 1'b0;
        n = 0;
        while (afu_c0_alm_full || afu_c1_alm_full)
        begin
            step();
            n++;
            if (n > wait_limit)
                rule_error("timed out waiting for credit almost-full to fall");
        end
        wait_drained("credit-limited requests to drain");

        // Mixed traffic under bursty FIU almost-full
        burst_fiu = 1'b1;
        req_left0 = 60;
        req_left1 = 60;
        wait_drained("bursty traffic to drain");
        burst_fiu = 1'b0;
        repeat (4) step();

        $display("all tests passed");
        $finish;
    end

endmodule

//--- files.f
hw/mpf_shim_pkg.sv
hw/mpf_req_map.sv
hw/mpf_tx_fifo.sv
hw/mpf_rsp_map.sv
hw/mpf_shim_top.sv
bench/mpf_shim_tb.sv

//--- hw/mpf_req_map.sv
// AFU request register stage that attaches the extension header fields.
// Side inputs are sampled in the same cycle as the matching valid.
// Fences leave with zero data and zero mask whatever the AFU drives.
// Reads on c1 are illegal and are flagged by an assertion.

`timescale 1ns/1ps

module mpf_req_map
(
    input  logic                          clk,
    input  logic                          arst_n,

    input  logic                          afu_c0_valid,
    input  logic [mpf_shim_pkg::addr_w-1:0]  afu_c0_addr,
    input  logic [mpf_shim_pkg::mdata_w-1:0] afu_c0_mdata,

    input  logic                          afu_c1_valid,
    input  mpf_shim_pkg::t_req_op         afu_c1_op,
    input  logic [mpf_shim_pkg::addr_w-1:0]  afu_c1_addr,
    input  logic [mpf_shim_pkg::data_w-1:0]  afu_c1_data,
    input  logic [mpf_shim_pkg::mdata_w-1:0] afu_c1_mdata,

    input  logic                          c0_ext_vaddr,
    input  logic                          c0_ext_order,
    input  logic                          c1_ext_vaddr,
    input  logic                          c1_ext_order,
    input  logic                          c1_pwrite_en,
    input  logic [mpf_shim_pkg::mask_w-1:0]  c1_pwrite_mask,

    output logic                             req0_valid,
    output logic [mpf_shim_pkg::c0_word_w-1:0] req0_word,
    output logic                             req1_valid,
    output logic [mpf_shim_pkg::c1_word_w-1:0] req1_word
);
    import mpf_shim_pkg::*;

    logic [data_w-1:0] c1_data;
    logic [mask_w-1:0] c1_mask;

    // A byte mask only applies to a full-line write with partial write enabled
    always_comb
    begin
        c1_data = afu_c1_data;
        c1_mask = '1;
        if (afu_c1_op == req_wrfence)
        begin
            c1_data = '0;
            c1_mask = '0;
        end
        else if (afu_c1_op == req_wrline && c1_pwrite_en)
            c1_mask = c1_pwrite_mask;
    end

    // Valids are the only control state in this stage
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            req0_valid <= 1'b0;
            req1_valid <= 1'b0;
        end
        else
        begin
            req0_valid <= afu_c0_valid;
            req1_valid <= afu_c1_valid;
        end
    end

    // Words only load on a transfer so idle cycles do not toggle the payload
    always_ff @(posedge clk)
    begin
        if (afu_c0_valid)
            req0_word <= {c0_ext_vaddr, c0_ext_order, afu_c0_mdata, afu_c0_addr};
        if (afu_c1_valid)
            req1_word <= {afu_c1_op, c1_ext_vaddr, c1_ext_order, c1_mask,
                          afu_c1_mdata, c1_data, afu_c1_addr};
    end

    // c1 is the write channel, reads must go out on c0
    c1_no_read: assert property (@(posedge clk) disable iff (!arst_n)
        afu_c1_valid |-> afu_c1_op != req_rdline)
        else $error("c1 request carries a read opcode");

endmodule

//--- hw/mpf_rsp_map.sv
// Response path toward the AFU and the shared credit counter.
// Responses are registered once, so the AFU sees them one cycle after the FIU.
// A request takes a credit when it enters a FIFO and returns it on its response,
// so queued requests count against the limit as well.
// afu_cX_alm_full is combinational from the FIFO flag and the counter.

`timescale 1ns/1ps

module mpf_rsp_map
(
    input  logic                             clk,
    input  logic                             arst_n,

    input  logic                             issue0,
    input  logic                             issue1,

    input  logic                             fiu_rx0_valid,
    input  logic [mpf_shim_pkg::data_w-1:0]  fiu_rx0_data,
    input  logic [mpf_shim_pkg::mdata_w-1:0] fiu_rx0_mdata,
    input  logic                             fiu_rx1_valid,
    input  mpf_shim_pkg::t_rsp_op            fiu_rx1_op,
    input  logic [mpf_shim_pkg::mdata_w-1:0] fiu_rx1_mdata,

    input  logic                             fifo0_alm_full,
    input  logic                             fifo1_alm_full,

    output logic                             afu_rx0_valid,
    output logic [mpf_shim_pkg::data_w-1:0]  afu_rx0_data,
    output logic [mpf_shim_pkg::mdata_w-1:0] afu_rx0_mdata,
    output logic                             afu_rx1_valid,
    output mpf_shim_pkg::t_rsp_op            afu_rx1_op,
    output logic [mpf_shim_pkg::mdata_w-1:0] afu_rx1_mdata,

    output logic                             afu_c0_alm_full,
    output logic                             afu_c1_alm_full
);
    import mpf_shim_pkg::*;

    logic [out_cnt_w-1:0] outstanding;
    logic [out_cnt_w-1:0] outstanding_next;
    logic                 credit_low;

    // Up to two issues and two responses can land in one cycle
    always_comb
    begin
        outstanding_next = outstanding;
        if (issue0)
            outstanding_next = outstanding_next + 1'b1;
        if (issue1)
            outstanding_next = outstanding_next + 1'b1;
        if (fiu_rx0_valid)
            outstanding_next = outstanding_next - 1'b1;
        if (fiu_rx1_valid)
            outstanding_next = outstanding_next - 1'b1;
    end

    assign credit_low      = outstanding >= out_cnt_w'(credit_level);
    assign afu_c0_alm_full = fifo0_alm_full || credit_low;
    assign afu_c1_alm_full = fifo1_alm_full || credit_low;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            outstanding   <= '0;
            afu_rx0_valid <= 1'b0;
            afu_rx1_valid <= 1'b0;
        end
        else
        begin
            outstanding   <= outstanding_next;
            afu_rx0_valid <= fiu_rx0_valid;
            afu_rx1_valid <= fiu_rx1_valid;
        end
    end

    // Response payload follows its valid by exactly one register
    always_ff @(posedge clk)
    begin
        afu_rx0_data  <= fiu_rx0_data;
        afu_rx0_mdata <= fiu_rx0_mdata;
        afu_rx1_op    <= fiu_rx1_op;
        afu_rx1_mdata <= fiu_rx1_mdata;
    end

    // The FIU can only answer requests that the shim has accepted
    no_rsp_idle: assert property (@(posedge clk) disable iff (!arst_n)
        (fiu_rx0_valid || fiu_rx1_valid) |-> outstanding != '0)
        else $error("FIU response with no request outstanding");

endmodule

//--- hw/mpf_shim_pkg.sv
// Shared widths, depths and opcodes for the host-channel shim.
// tx_depth need not be a power of two since the FIFO pointers wrap explicitly.
// The almost-full slack must cover the mapper register plus one more AFU cycle.
// Request words are packed vectors and their layout is fixed by the mapper.

package mpf_shim_pkg;

    // Line and tag widths
    localparam int addr_w  = 32;
    localparam int data_w  = 64;
    localparam int mdata_w = 16;
    localparam int mask_w  = data_w / 8;
    localparam int op_w    = 2;

    // Request FIFO sizing and flow control
    localparam int tx_depth       = 8;
    localparam int alm_full_slack = 2;
    localparam int fifo_ptr_w     = $clog2(tx_depth);
    localparam int fifo_cnt_w     = $clog2(tx_depth + 1);
    localparam int fifo_alm_level = tx_depth - alm_full_slack;

    // Credits are shared by c0 and c1 and taken when a request is accepted
    localparam int max_outstanding = 16;
    localparam int out_cnt_w       = $clog2(max_outstanding) + 1;
    localparam int credit_level    = max_outstanding - alm_full_slack;

    // c0 word is {vaddr, order, mdata, addr}
    localparam int c0_word_w = 2 + mdata_w + addr_w;

    // c1 word is {op, vaddr, order, mask, mdata, data, addr}
    localparam int c1_word_w = op_w + 2 + mask_w + mdata_w + data_w + addr_w;

    // Request opcodes where c0 only ever carries reads
    typedef enum logic [op_w-1:0]
    {
        req_rdline  = 2'd0,
        req_wrline  = 2'd1,
        req_wrfence = 2'd2
    } t_req_op;

    // Response opcodes as returned by the FIU
    typedef enum logic [op_w-1:0]
    {
        rsp_rdline  = 2'd0,
        rsp_wrline  = 2'd1,
        rsp_wrfence = 2'd2
    } t_rsp_op;

endpackage

//--- hw/mpf_shim_top.sv
// Top level of the shim between one AFU and the FIU.
// AFU request to FIU request takes two cycles when the FIU is not almost full.
// The AFU must stop within alm_full_slack cycles of afu_cX_alm_full rising.
// Only the c0 read and c1 write and fence channels exist here, MMIO is not handled.

`timescale 1ns/1ps

module mpf_shim_top
(
    input  logic                             clk,
    input  logic                             arst_n,

    // AFU requests and extension side inputs
    input  logic                             afu_c0_valid,
    input  logic [mpf_shim_pkg::addr_w-1:0]  afu_c0_addr,
    input  logic [mpf_shim_pkg::mdata_w-1:0] afu_c0_mdata,
    input  logic                             afu_c1_valid,
    input  mpf_shim_pkg::t_req_op            afu_c1_op,
    input  logic [mpf_shim_pkg::addr_w-1:0]  afu_c1_addr,
    input  logic [mpf_shim_pkg::data_w-1:0]  afu_c1_data,
    input  logic [mpf_shim_pkg::mdata_w-1:0] afu_c1_mdata,
    input  logic                             c0_ext_vaddr,
    input  logic                             c0_ext_order,
    input  logic                             c1_ext_vaddr,
    input  logic                             c1_ext_order,
    input  logic                             c1_pwrite_en,
    input  logic [mpf_shim_pkg::mask_w-1:0]  c1_pwrite_mask,

    // AFU flow control and responses
    output logic                             afu_c0_alm_full,
    output logic                             afu_c1_alm_full,
    output logic                             afu_rx0_valid,
    output logic [mpf_shim_pkg::data_w-1:0]  afu_rx0_data,
    output logic [mpf_shim_pkg::mdata_w-1:0] afu_rx0_mdata,
    output logic                             afu_rx1_valid,
    output mpf_shim_pkg::t_rsp_op            afu_rx1_op,
    output logic [mpf_shim_pkg::mdata_w-1:0] afu_rx1_mdata,

    // FIU requests
    output logic                             fiu_c0_valid,
    output logic [mpf_shim_pkg::addr_w-1:0]  fiu_c0_addr,
    output logic [mpf_shim_pkg::mdata_w-1:0] fiu_c0_mdata,
    output logic                             fiu_c0_vaddr,
    output logic                             fiu_c0_order,
    output logic                             fiu_c1_valid,
    output mpf_shim_pkg::t_req_op            fiu_c1_op,
    output logic [mpf_shim_pkg::addr_w-1:0]  fiu_c1_addr,
    output logic [mpf_shim_pkg::data_w-1:0]  fiu_c1_data,
    output logic [mpf_shim_pkg::mask_w-1:0]  fiu_c1_mask,
    output logic [mpf_shim_pkg::mdata_w-1:0] fiu_c1_mdata,
    output logic                             fiu_c1_vaddr,
    output logic                             fiu_c1_order,

    // FIU flow control and responses
    input  logic                             fiu_c0_alm_full,
    input  logic                             fiu_c1_alm_full,
    input  logic                             fiu_rx0_valid,
    input  logic [mpf_shim_pkg::data_w-1:0]  fiu_rx0_data,
    input  logic [mpf_shim_pkg::mdata_w-1:0] fiu_rx0_mdata,
    input  logic                             fiu_rx1_valid,
    input  mpf_shim_pkg::t_rsp_op            fiu_rx1_op,
    input  logic [mpf_shim_pkg::mdata_w-1:0] fiu_rx1_mdata
);
    import mpf_shim_pkg::*;

    logic                 req0_valid;
    logic [c0_word_w-1:0] req0_word;
    logic                 req1_valid;
    logic [c1_word_w-1:0] req1_word;
    logic [c0_word_w-1:0] fifo0_word;
    logic [c1_word_w-1:0] fifo1_word;
    logic                 fifo0_alm_full;
    logic                 fifo1_alm_full;
    logic [op_w-1:0]      fiu_c1_op_bits;

    mpf_req_map mpf_req_map_i
    (
        .clk            (clk),
        .arst_n         (arst_n),
        .afu_c0_valid   (afu_c0_valid),
        .afu_c0_addr    (afu_c0_addr),
        .afu_c0_mdata   (afu_c0_mdata),
        .afu_c1_valid   (afu_c1_valid),
        .afu_c1_op      (afu_c1_op),
        .afu_c1_addr    (afu_c1_addr),
        .afu_c1_data    (afu_c1_data),
        .afu_c1_mdata   (afu_c1_mdata),
        .c0_ext_vaddr   (c0_ext_vaddr),
        .c0_ext_order   (c0_ext_order),
        .c1_ext_vaddr   (c1_ext_vaddr),
        .c1_ext_order   (c1_ext_order),
        .c1_pwrite_en   (c1_pwrite_en),
        .c1_pwrite_mask (c1_pwrite_mask),
        .req0_valid     (req0_valid),
        .req0_word      (req0_word),
        .req1_valid     (req1_valid),
        .req1_word      (req1_word)
    );

    // Read channel FIFO, blocked by the FIU c0 almost-full
    mpf_tx_fifo #(.word_w(c0_word_w)) mpf_tx_fifo_c0_i
    (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (req0_valid),
        .push_word (req0_word),
        .pop_block (fiu_c0_alm_full),
        .out_valid (fiu_c0_valid),
        .out_word  (fifo0_word),
        .alm_full  (fifo0_alm_full)
    );

    // Write and fence channel FIFO
    mpf_tx_fifo #(.word_w(c1_word_w)) mpf_tx_fifo_c1_i
    (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (req1_valid),
        .push_word (req1_word),
        .pop_block (fiu_c1_alm_full),
        .out_valid (fiu_c1_valid),
        .out_word  (fifo1_word),
        .alm_full  (fifo1_alm_full)
    );

    // Field order matches the packing in the mapper
    assign {fiu_c0_vaddr, fiu_c0_order, fiu_c0_mdata, fiu_c0_addr} = fifo0_word;
    assign {fiu_c1_op_bits, fiu_c1_vaddr, fiu_c1_order, fiu_c1_mask,
            fiu_c1_mdata, fiu_c1_data, fiu_c1_addr} = fifo1_word;
    assign fiu_c1_op = t_req_op'(fiu_c1_op_bits);

    // Credits are taken as requests enter the FIFOs
    mpf_rsp_map mpf_rsp_map_i
    (
        .clk             (clk),
        .arst_n          (arst_n),
        .issue0          (req0_valid),
        .issue1          (req1_valid),
        .fiu_rx0_valid   (fiu_rx0_valid),
        .fiu_rx0_data    (fiu_rx0_data),
        .fiu_rx0_mdata   (fiu_rx0_mdata),
        .fiu_rx1_valid   (fiu_rx1_valid),
        .fiu_rx1_op      (fiu_rx1_op),
        .fiu_rx1_mdata   (fiu_rx1_mdata),
        .fifo0_alm_full  (fifo0_alm_full),
        .fifo1_alm_full  (fifo1_alm_full),
        .afu_rx0_valid   (afu_rx0_valid),
        .afu_rx0_data    (afu_rx0_data),
        .afu_rx0_mdata   (afu_rx0_mdata),
        .afu_rx1_valid   (afu_rx1_valid),
        .afu_rx1_op      (afu_rx1_op),
        .afu_rx1_mdata   (afu_rx1_mdata),
        .afu_c0_alm_full (afu_c0_alm_full),
        .afu_c1_alm_full (afu_c1_alm_full)
    );

endmodule

//--- hw/mpf_tx_fifo.sv
// Request FIFO for one channel, used for both c0 and c1 with their own widths.
// The head leaves in any cycle the FIFO holds data and the FIU is not almost full,
// so out_valid is combinational on pop_block.
// alm_full comes from the entry count alone, upstream pipeline stages are
// covered by the slack.

`timescale 1ns/1ps

module mpf_tx_fifo
#(
    parameter int word_w = 8
)
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              push,
    input  logic [word_w-1:0] push_word,
    input  logic              pop_block,
    output logic              out_valid,
    output logic [word_w-1:0] out_word,
    output logic              alm_full
);
    import mpf_shim_pkg::*;

    logic [word_w-1:0]     mem [tx_depth];
    logic [fifo_ptr_w-1:0] wr_ptr;
    logic [fifo_ptr_w-1:0] rd_ptr;
    logic [fifo_cnt_w-1:0] count;
    logic                  pop;

    // Pointers wrap explicitly so a depth other than a power of two still works
    function automatic logic [fifo_ptr_w-1:0] ptr_inc(input logic [fifo_ptr_w-1:0] ptr);
        if (ptr == fifo_ptr_w'(tx_depth - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    assign pop       = (count != '0) && !pop_block;
    assign out_valid = pop;
    assign out_word  = mem[rd_ptr];
    assign alm_full  = count >= fifo_cnt_w'(fifo_alm_level);

    // Pointer and count state
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= ptr_inc(wr_ptr);
            if (pop)
                rd_ptr <= ptr_inc(rd_ptr);

            // A push and a pop in the same cycle leave the count unchanged
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    // Storage array
    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= push_word;
    end

    // The sender upstream must have honoured alm_full early enough
    no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
        push |-> count < fifo_cnt_w'(tx_depth))
        else $error("push into a full request FIFO");

endmodule
